/* logic/rob_consts.svh */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// buffer geometry
`define ROB_SIZE        16
`define ROB_IDX_W       4

// group sizes per cycle
`define DISPATCH_WIDTH  2
`define COMMIT_WIDTH    2
`define WB_PORTS        2

// exception code, all ones means no exception
`define EXC_W           4
`define EXC_NONE        4'b1111

// register index widths
`define PREG_W          6
`define AREG_W          5

`endif

/* logic/rob_pkg.sv */
`include "rob_consts.svh"

package rob_pkg;

    // entry index with the wrap bit on top
    typedef logic [`ROB_IDX_W:0] rob_idx_t;

    // occupancy, zero up to ROB_SIZE
    typedef logic [`ROB_IDX_W:0] rob_cnt_t;

    typedef logic [$clog2(`COMMIT_WIDTH):0]   commit_num_t;
    typedef logic [$clog2(`DISPATCH_WIDTH):0] dispatch_num_t;

    typedef logic [`EXC_W-1:0] exc_code_t;

    typedef struct packed {
        logic              we;
        logic              mem;
        logic              store;
        logic [`AREG_W-1:0] vrd;
        logic [`PREG_W-1:0] prd;
        logic [`PREG_W-1:0] old_prd;
    } rob_payload_t;

    // valid mask is contiguous from slot 0
    typedef struct packed {
        logic [`DISPATCH_WIDTH-1:0]         valid;
        rob_payload_t [`DISPATCH_WIDTH-1:0] slot;
    } dispatch_req_t;

    typedef struct packed {
        logic      en;
        rob_idx_t  idx;
        exc_code_t exccode;
    } wb_port_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic              mem;
        logic              store;
        logic [`AREG_W-1:0] vrd;
        logic [`PREG_W-1:0] prd;
        logic [`PREG_W-1:0] old_prd;
    } commit_slot_t;

    typedef struct packed {
        commit_slot_t [`COMMIT_WIDTH-1:0] slot;
        rob_idx_t                         idx;
        commit_num_t                      num;
    } commit_bus_t;

    typedef struct packed {
        logic      en;
        rob_idx_t  idx;
        exc_code_t exccode;
    } redirect_t;

endpackage

/* logic/rob_ptr_ctrl.sv */
`timescale 1ns/10ps
`include "rob_consts.svh"

module rob_ptr_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`DISPATCH_WIDTH-1:0] dis_valid,
    input  rob_pkg::commit_num_t       commit_num,
    input  logic                       flush,
    output rob_pkg::rob_idx_t          head,
    output rob_pkg::rob_idx_t          tail,
    output rob_pkg::rob_cnt_t          count,
    output logic                       accept,
    output logic                       full
);

    rob_pkg::dispatch_num_t grp_num;
    rob_pkg::dispatch_num_t acc_num;
    rob_pkg::rob_cnt_t      free_num;

    // size of the offered group
    always_comb begin
        grp_num = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            grp_num = grp_num + rob_pkg::dispatch_num_t'(dis_valid[i]);
        end
    end

    assign free_num = rob_pkg::rob_cnt_t'(`ROB_SIZE) - count;

    // the whole group waits if it does not fit, and nothing enters during a flush
    assign full    = flush || (free_num < rob_pkg::rob_cnt_t'(grp_num));
    assign accept  = (|dis_valid) && !full;
    assign acc_num = accept ? grp_num : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head <= head + rob_pkg::rob_idx_t'(commit_num);
            if (flush) begin
                // drop everything younger than the excepting entry
                tail  <= head;
                count <= '0;
            end else begin
                tail  <= tail + rob_pkg::rob_idx_t'(acc_num);
                count <= count + rob_pkg::rob_cnt_t'(acc_num)
                         - rob_pkg::rob_cnt_t'(commit_num);
            end
        end
    end

    a_count_limit: assert property (
        @(posedge clk) disable iff (rst)
        count <= rob_pkg::rob_cnt_t'(`ROB_SIZE)
    );

endmodule

/* logic/rob_entry_store.sv */
`timescale 1ns/10ps
`include "rob_consts.svh"

module rob_entry_store (
    input  logic                                      clk,
    input  rob_pkg::dispatch_req_t                    dis,
    input  logic                                      accept,
    input  rob_pkg::rob_idx_t                         tail,
    input  rob_pkg::rob_idx_t                         head,
    output rob_pkg::rob_payload_t [`COMMIT_WIDTH-1:0] head_payload
);

    rob_pkg::rob_payload_t entries [`ROB_SIZE];

    logic [`ROB_IDX_W-1:0] widx [`DISPATCH_WIDTH];
    logic [`ROB_IDX_W-1:0] ridx [`COMMIT_WIDTH];

    // slot i of a group lands at tail+i, wrapping inside the array
    for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_widx
        assign widx[i] = tail[`ROB_IDX_W-1:0] + `ROB_IDX_W'(i);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (accept && dis.valid[i]) begin
                entries[widx[i]] <= dis.slot[i];
            end
        end
    end

    // head slots are read without a register
    for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : g_read
        assign ridx[i]         = head[`ROB_IDX_W-1:0] + `ROB_IDX_W'(i);
        assign head_payload[i] = entries[ridx[i]];
    end

endmodule

/* logic/rob_status_table.sv */
`timescale 1ns/10ps
`include "rob_consts.svh"

module rob_status_table (
    input  logic                                   clk,
    input  logic                                   rst,
    input  rob_pkg::wb_port_t [`WB_PORTS-1:0]      wb,
    input  logic [`DISPATCH_WIDTH-1:0]             dis_valid,
    input  logic                                   accept,
    input  logic                                   flush,
    input  rob_pkg::rob_idx_t                      tail,
    input  rob_pkg::rob_idx_t                      head,
    output logic [`COMMIT_WIDTH-1:0]               head_done,
    output rob_pkg::exc_code_t [`COMMIT_WIDTH-1:0] head_exc
);

    logic [`ROB_SIZE-1:0] done;
    rob_pkg::exc_code_t   exc_codes [`ROB_SIZE];

    logic [`ROB_IDX_W-1:0] aidx [`DISPATCH_WIDTH];
    logic [`ROB_IDX_W-1:0] ridx [`COMMIT_WIDTH];

    for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_aidx
        assign aidx[i] = tail[`ROB_IDX_W-1:0] + `ROB_IDX_W'(i);
    end

    // a new entry starts not done; write-backs never name a slot allocated this cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= '0;
        end else begin
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                if (accept && dis_valid[i]) begin
                    done[aidx[i]] <= 1'b0;
                end
            end
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wb[p].en && !flush) begin
                    done[wb[p].idx[`ROB_IDX_W-1:0]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb[p].en && !flush) begin
                exc_codes[wb[p].idx[`ROB_IDX_W-1:0]] <= wb[p].exccode;
            end
        end
    end

    for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : g_read
        assign ridx[i]      = head[`ROB_IDX_W-1:0] + `ROB_IDX_W'(i);
        assign head_done[i] = done[ridx[i]];
        assign head_exc[i]  = exc_codes[ridx[i]];
    end

    for (genvar p = 0; p < `WB_PORTS; p++) begin : g_wb_chk
        for (genvar q = p + 1; q < `WB_PORTS; q++) begin : g_pair
            a_wb_distinct: assert property (
                @(posedge clk) disable iff (rst)
                (wb[p].en && wb[q].en) |-> (wb[p].idx != wb[q].idx)
            );
        end
    end

endmodule

/* logic/rob_commit_sel.sv */
`timescale 1ns/10ps
`include "rob_consts.svh"

module rob_commit_sel (
    input  logic                                      clk,
    input  logic                                      rst,
    input  rob_pkg::rob_cnt_t                         count,
    input  rob_pkg::rob_idx_t                         head,
    input  logic [`COMMIT_WIDTH-1:0]                  head_done,
    input  rob_pkg::exc_code_t [`COMMIT_WIDTH-1:0]    head_exc,
    input  rob_pkg::rob_payload_t [`COMMIT_WIDTH-1:0] head_payload,
    output rob_pkg::commit_num_t                      commit_num,
    output logic                                      flush,
    output rob_pkg::commit_bus_t                      commit,
    output rob_pkg::redirect_t                        redirect
);

    localparam int SEL_W = $clog2(`COMMIT_WIDTH);

    logic [`COMMIT_WIDTH-1:0] excepts;
    logic [`COMMIT_WIDTH-1:0] commit_en;
    logic                     exc_hit;
    logic [SEL_W-1:0]         exc_sel;

    logic [`COMMIT_WIDTH-1:0]                  valid_q;
    rob_pkg::commit_num_t                      num_q;
    rob_pkg::rob_idx_t                         idx_q;
    rob_pkg::rob_payload_t [`COMMIT_WIDTH-1:0] pay_q;

    logic               exc_pend;
    rob_pkg::rob_idx_t  exc_idx_q;
    rob_pkg::exc_code_t exc_code_q;
    logic               redir_en_q;
    rob_pkg::rob_idx_t  redir_idx_q;
    rob_pkg::exc_code_t redir_code_q;

    // take occupied, done head slots in order and stop after the first exception
    always_comb begin
        logic open;
        open       = !exc_pend && !redir_en_q;
        commit_en  = '0;
        commit_num = '0;
        exc_hit    = 1'b0;
        exc_sel    = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            excepts[i] = (head_exc[i] != `EXC_NONE);
            if (open && (count > rob_pkg::rob_cnt_t'(i)) && head_done[i]) begin
                commit_en[i] = 1'b1;
                commit_num   = commit_num + rob_pkg::commit_num_t'(1);
                if (excepts[i]) begin
                    exc_hit = 1'b1;
                    exc_sel = SEL_W'(i);
                    open    = 1'b0;
                end
            end else begin
                open = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q    <= '0;
            num_q      <= '0;
            exc_pend   <= 1'b0;
            redir_en_q <= 1'b0;
        end else begin
            valid_q    <= commit_en;
            num_q      <= commit_num;
            exc_pend   <= exc_hit;
            redir_en_q <= exc_pend;
        end
    end

    always_ff @(posedge clk) begin
        idx_q <= head;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            pay_q[i] <= head_payload[i];
            // excepting entry retires but must not update the register map
            pay_q[i].we <= head_payload[i].we && !(commit_en[i] && excepts[i]);
        end
        if (exc_hit) begin
            exc_idx_q  <= head + rob_pkg::rob_idx_t'(exc_sel);
            exc_code_q <= head_exc[exc_sel];
        end
        redir_idx_q  <= exc_idx_q;
        redir_code_q <= exc_code_q;
    end

    always_comb begin
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            commit.slot[i].valid   = valid_q[i];
            commit.slot[i].we      = pay_q[i].we;
            commit.slot[i].mem     = pay_q[i].mem;
            commit.slot[i].store   = pay_q[i].store;
            commit.slot[i].vrd     = pay_q[i].vrd;
            commit.slot[i].prd     = pay_q[i].prd;
            commit.slot[i].old_prd = pay_q[i].old_prd;
        end
        commit.idx = idx_q;
        commit.num = num_q;
    end

    assign redirect.en      = redir_en_q;
    assign redirect.idx     = redir_idx_q;
    assign redirect.exccode = redir_code_q;
    assign flush            = redir_en_q;

    // valid slots form a run starting at slot 0
    a_commit_prefix: assert property (
        @(posedge clk) disable iff (rst)
        (valid_q & (valid_q + `COMMIT_WIDTH'(1))) == '0
    );

endmodule

/* logic/rob_top.sv */
`timescale 1ns/10ps
`include "rob_consts.svh"

module rob_top (
    input  logic                             clk,
    input  logic                             rst,
    input  rob_pkg::dispatch_req_t           dis,
    input  rob_pkg::wb_port_t [`WB_PORTS-1:0] wb,
    output rob_pkg::rob_idx_t                alloc_idx,
    output logic                             full,
    output rob_pkg::commit_bus_t             commit,
    output rob_pkg::redirect_t               redirect
);

    rob_pkg::rob_idx_t    head;
    rob_pkg::rob_idx_t    tail;
    rob_pkg::rob_cnt_t    count;
    logic                 accept;
    logic                 flush;
    rob_pkg::commit_num_t commit_num;

    logic [`COMMIT_WIDTH-1:0]                  head_done;
    rob_pkg::exc_code_t [`COMMIT_WIDTH-1:0]    head_exc;
    rob_pkg::rob_payload_t [`COMMIT_WIDTH-1:0] head_payload;

    assign alloc_idx = tail;

    rob_ptr_ctrl ptr_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .dis_valid  (dis.valid),
        .commit_num (commit_num),
        .flush      (flush),
        .head       (head),
        .tail       (tail),
        .count      (count),
        .accept     (accept),
        .full       (full)
    );

    rob_entry_store entry_store_i (
        .clk          (clk),
        .dis          (dis),
        .accept       (accept),
        .tail         (tail),
        .head         (head),
        .head_payload (head_payload)
    );

    rob_status_table status_table_i (
        .clk       (clk),
        .rst       (rst),
        .wb        (wb),
        .dis_valid (dis.valid),
        .accept    (accept),
        .flush     (flush),
        .tail      (tail),
        .head      (head),
        .head_done (head_done),
        .head_exc  (head_exc)
    );

    rob_commit_sel commit_sel_i (
        .clk          (clk),
        .rst          (rst),
        .count        (count),
        .head         (head),
        .head_done    (head_done),
        .head_exc     (head_exc),
        .head_payload (head_payload),
        .commit_num   (commit_num),
        .flush        (flush),
        .commit       (commit),
        .redirect     (redirect)
    );

endmodule

/* testbench/tb_rob_model.svh */
`ifndef TB_ROB_MODEL_SVH
`define TB_ROB_MODEL_SVH

// model of the buffer, slots kept by the low bits of the entry index
rob_pkg::rob_payload_t m_pay [`ROB_SIZE];
rob_pkg::exc_code_t    m_exc [`ROB_SIZE];
logic [`ROB_SIZE-1:0]  m_done;
rob_pkg::rob_idx_t     m_head;
rob_pkg::rob_idx_t     m_tail;
int                    m_count;
logic                  m_exc_pend;
logic                  m_redir;
rob_pkg::rob_idx_t     m_exc_idx;
rob_pkg::exc_code_t    m_exc_code;

task automatic model_reset();
    m_done     = '0;
    m_head     = '0;
    m_tail     = '0;
    m_count    = 0;
    m_exc_pend = 1'b0;
    m_redir    = 1'b0;
endtask

// full while a redirect is out, or when the offered group does not fit
function automatic logic expected_full(logic [`DISPATCH_WIDTH-1:0] valid);
    int want;
    want = 0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        want += valid[i];
    end
    return m_redir || ((`ROB_SIZE - m_count) < want);
endfunction

// one rising edge, with d, acc and w as sampled there
task automatic advance_model(
    input  rob_pkg::dispatch_req_t            d,
    input  logic                              acc,
    input  rob_pkg::wb_port_t [`WB_PORTS-1:0] w,
    output rob_pkg::commit_bus_t              exp_c,
    output rob_pkg::redirect_t                exp_r
);
    logic                  open;
    logic                  hit;
    int                    n;
    int                    acc_n;
    logic [`ROB_IDX_W-1:0] s;
    exp_c         = '0;
    exp_r         = '0;
    exp_r.en      = m_exc_pend;
    exp_r.idx     = m_exc_idx;
    exp_r.exccode = m_exc_code;
    open  = !m_exc_pend && !m_redir;
    hit   = 1'b0;
    n     = 0;
    acc_n = 0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
        s = m_head[`ROB_IDX_W-1:0] + `ROB_IDX_W'(i);
        if (open && m_count > i && m_done[s]) begin
            exp_c.slot[i] = {1'b1, m_pay[s]};
            n++;
            if (m_exc[s] != `EXC_NONE) begin
                exp_c.slot[i].we = 1'b0;
                m_exc_idx  = m_head + rob_pkg::rob_idx_t'(i);
                m_exc_code = m_exc[s];
                hit        = 1'b1;
                open       = 1'b0;
            end
        end else begin
            open = 1'b0;
        end
    end
    exp_c.idx = m_head;
    exp_c.num = rob_pkg::commit_num_t'(n);
    // write-backs are dropped while the flush is pending
    for (int p = 0; p < `WB_PORTS; p++) begin
        if (w[p].en && !m_redir) begin
            m_done[w[p].idx[`ROB_IDX_W-1:0]] = 1'b1;
            m_exc[w[p].idx[`ROB_IDX_W-1:0]]  = w[p].exccode;
        end
    end
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        if (acc && d.valid[i]) begin
            s         = m_tail[`ROB_IDX_W-1:0] + `ROB_IDX_W'(i);
            m_pay[s]  = d.slot[i];
            m_done[s] = 1'b0;
            acc_n++;
        end
    end
    m_head = m_head + rob_pkg::rob_idx_t'(n);
    if (m_redir) begin
        m_tail  = m_head;
        m_count = 0;
    end else begin
        m_tail  = m_tail + rob_pkg::rob_idx_t'(acc_n);
        m_count = m_count + acc_n - n;
    end
    m_redir    = m_exc_pend;
    m_exc_pend = hit;
endtask

`endif

/* testbench/tb_rob.sv */
`timescale 1ns/10ps
`include "rob_consts.svh"

module tb_rob;

    localparam int MIX_CYCLES   = 600;
    localparam int FILL_CYCLES  = 300;
    localparam int DRAIN_LIMIT  = 200;
    localparam int TOTAL_CYCLES = 4 + MIX_CYCLES + FILL_CYCLES + DRAIN_LIMIT;
    localparam int PAY_W        = $bits(rob_pkg::rob_payload_t);

    logic                              clk;
    logic                              rst;
    rob_pkg::dispatch_req_t            dis;
    rob_pkg::wb_port_t [`WB_PORTS-1:0] wb;
    rob_pkg::rob_idx_t                 alloc_idx;
    logic                              full;
    rob_pkg::commit_bus_t              commit;
    rob_pkg::redirect_t                redirect;

    integer            seed;
    int                errors;
    int                tests_run;
    int                tests_failed;
    int                redirects;
    int                stalls;
    logic              accepted;
    logic              flush_seen;
    rob_pkg::rob_idx_t flush_idx;

    `include "tb_rob_model.svh"

    rob_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .dis       (dis),
        .wb        (wb),
        .alloc_idx (alloc_idx),
        .full      (full),
        .commit    (commit),
        .redirect  (redirect)
    );

    always #50 clk = ~clk;

    initial begin
        #((TOTAL_CYCLES + 50) * 100);
        $display("timeout: the run did not end within %0d cycles", TOTAL_CYCLES + 50);
        $display("Testbench failed");
        $finish;
    end

    task automatic note_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic end_test(string name, int start);
        tests_run++;
        if (errors == start) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start);
        end
    endtask

    task automatic check_outputs(rob_pkg::commit_bus_t exp_c, rob_pkg::redirect_t exp_r);
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (commit.slot[i].valid !== exp_c.slot[i].valid) begin
                note_mismatch($sformatf("commit.slot[%0d].valid", i),
                              commit.slot[i].valid, exp_c.slot[i].valid);
            end else if (exp_c.slot[i].valid && commit.slot[i] !== exp_c.slot[i]) begin
                note_mismatch($sformatf("commit.slot[%0d]", i), commit.slot[i], exp_c.slot[i]);
            end
        end
        if (commit.num !== exp_c.num) begin
            note_mismatch("commit.num", commit.num, exp_c.num);
        end
        if (exp_c.num != 0 && commit.idx !== exp_c.idx) begin
            note_mismatch("commit.idx", commit.idx, exp_c.idx);
        end
        if (redirect.en !== exp_r.en) begin
            note_mismatch("redirect.en", redirect.en, exp_r.en);
        end
        if (exp_r.en && redirect.idx !== exp_r.idx) begin
            note_mismatch("redirect.idx", redirect.idx, exp_r.idx);
        end
        if (exp_r.en && redirect.exccode !== exp_r.exccode) begin
            note_mismatch("redirect.exccode", redirect.exccode, exp_r.exccode);
        end
    endtask

    // check the last edge, then drive the next group and write-backs
    task automatic run_cycle(int wb_pct, int dis_pct);
        rob_pkg::commit_bus_t              exp_c;
        rob_pkg::redirect_t                exp_r;
        rob_pkg::dispatch_req_t            nd;
        rob_pkg::wb_port_t [`WB_PORTS-1:0] nw;
        rob_pkg::rob_idx_t                 pend [$];
        rob_pkg::rob_idx_t                 idx;
        int                                k;
        logic                              exp_full;
        @(negedge clk);
        advance_model(dis, accepted, wb, exp_c, exp_r);
        check_outputs(exp_c, exp_r);
        if (flush_seen && alloc_idx !== rob_pkg::rob_idx_t'(flush_idx + 1)) begin
            note_mismatch("alloc_idx after flush", alloc_idx,
                          rob_pkg::rob_idx_t'(flush_idx + 1));
        end
        flush_seen = exp_r.en;
        flush_idx  = exp_r.idx;
        if (exp_r.en) begin
            redirects++;
        end
        nd = '0;
        nw = '0;
        if ($unsigned($random(seed)) % 100 < dis_pct) begin
            k        = 1 + $unsigned($random(seed)) % `DISPATCH_WIDTH;
            nd.valid = `DISPATCH_WIDTH'((1 << k) - 1);
        end
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            nd.slot[i] = PAY_W'($random(seed));
        end
        // pending means allocated and not yet written back
        for (int i = 0; i < m_count; i++) begin
            idx = m_head + rob_pkg::rob_idx_t'(i);
            if (!m_done[idx[`ROB_IDX_W-1:0]]) begin
                pend.push_back(idx);
            end
        end
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (!m_redir && pend.size() > 0 && $unsigned($random(seed)) % 100 < wb_pct) begin
                k             = $unsigned($random(seed)) % pend.size();
                nw[p].en      = 1'b1;
                nw[p].idx     = pend[k];
                nw[p].exccode = `EXC_NONE;
                if ($unsigned($random(seed)) % 8 == 0) begin
                    nw[p].exccode = rob_pkg::exc_code_t'($unsigned($random(seed)) % 15);
                end
                pend.delete(k);
            end
        end
        dis = nd;
        wb  = nw;
        #1;
        exp_full = expected_full(nd.valid);
        if (full !== exp_full) begin
            note_mismatch("full", full, exp_full);
        end
        if (alloc_idx !== m_tail) begin
            note_mismatch("alloc_idx", alloc_idx, m_tail);
        end
        accepted = (|nd.valid) && !exp_full;
        if ((|nd.valid) && exp_full) begin
            stalls++;
        end
    endtask

    initial begin
        int start;
        int waited;
        seed         = 58773;
        clk          = 1'b0;
        rst          = 1'b1;
        dis          = '0;
        wb           = '0;
        accepted     = 1'b0;
        flush_seen   = 1'b0;
        flush_idx    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        redirects    = 0;
        stalls       = 0;
        model_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;

        start = errors;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (commit.slot[i].valid !== 1'b0) begin
                note_mismatch($sformatf("commit.slot[%0d].valid", i), commit.slot[i].valid, 0);
            end
        end
        if (commit.num !== '0) begin
            note_mismatch("commit.num", commit.num, 0);
        end
        if (redirect.en !== 1'b0) begin
            note_mismatch("redirect.en", redirect.en, 0);
        end
        if (full !== 1'b0) begin
            note_mismatch("full", full, 0);
        end
        if (alloc_idx !== '0) begin
            note_mismatch("alloc_idx", alloc_idx, 0);
        end
        end_test("reset_values", start);

        start = errors;
        repeat (MIX_CYCLES) run_cycle(60, 70);
        end_test("mixed_traffic", start);

        // slow write-backs let the buffer fill up
        start  = errors;
        stalls = 0;
        repeat (FILL_CYCLES) run_cycle(10, 90);
        if (stalls == 0) begin
            $display("full was never raised while the buffer was being filled");
            errors++;
        end
        end_test("fill_and_stall", start);

        start  = errors;
        waited = 0;
        while ((m_count != 0 || m_exc_pend || m_redir) && waited < DRAIN_LIMIT) begin
            run_cycle(100, 0);
            waited++;
        end
        if (m_count != 0) begin
            $display("buffer still held %0d entries after %0d drain cycles", m_count, waited);
            errors++;
        end
        if (redirects == 0) begin
            $display("no exception redirect was seen during the run");
            errors++;
        end
        end_test("drain", start);

        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+logic
+incdir+testbench
logic/rob_pkg.sv
logic/rob_ptr_ctrl.sv
logic/rob_entry_store.sv
logic/rob_status_table.sv
logic/rob_commit_sel.sv
logic/rob_top.sv
testbench/tb_rob.sv

/* Bender.yml */
package:
  name: rob_reorder_buffer

sources:
  - include_dirs:
      - logic
    files:
      - logic/rob_pkg.sv
      - logic/rob_ptr_ctrl.sv
      - logic/rob_entry_store.sv
      - logic/rob_status_table.sv
      - logic/rob_commit_sel.sv
      - logic/rob_top.sv
  - target: simulation
    include_dirs:
      - logic
      - testbench
    files:
      - testbench/tb_rob.sv
